// ==== Bender.yml ====
package:
  name: rtab

sources:
  - include_dirs:
      - logic
    files:
      - logic/rtab_pkg.sv
      - logic/rtab_alloc.sv
      - logic/rtab_entry.sv
      - logic/rtab_pop.sv
      - logic/rtab_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/rtab_tb.sv

// ==== logic/rtab_alloc.sv ====
/* Allocation side of the replay table. Picks the lowest free entry,
   reports line hits against the checked line and marks the tail to link */
`include "rtab_settings.svh"

module rtab_alloc (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic                                     alloc_i,
    input  logic                                     alloc_link_i,
    input  rtab_pkg::rtab_status_t [`RTAB_ENTRIES-1:0] status_i,
    output logic [`RTAB_ENTRIES-1:0]                 alloc_bv_o,
    output logic                                     alloc_head_o,
    output logic [`RTAB_ENTRIES-1:0]                 link_bv_o,
    output rtab_pkg::rtab_ptr_t                      alloc_ptr_o,
    output logic                                     check_hit_o,
    output logic                                     full_o,
    output logic                                     empty_o
);
    localparam int N = `RTAB_ENTRIES;

    logic [N-1:0] valid;
    logic [N-1:0] tail_hit;
    logic [N-1:0] free_bv;

    always_comb begin : status_split
        for (int i = 0; i < N; i++) begin
            valid[i]    = status_i[i].valid;
            tail_hit[i] = status_i[i].line_hit & status_i[i].tail;
        end
    end

    // Scan downwards so that the lowest free entry is the one left
    always_comb begin : free_scan
        free_bv     = '0;
        alloc_ptr_o = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_bv     = '0;
                free_bv[i]  = 1'b1;
                alloc_ptr_o = rtab_pkg::rtab_ptr_t'(i);
            end
        end
    end

    assign alloc_bv_o   = free_bv & {N{alloc_i | alloc_link_i}};
    assign alloc_head_o = alloc_i;
    assign link_bv_o    = tail_hit & {N{alloc_link_i}};

    assign check_hit_o = |tail_hit;
    assign full_o      = &valid;
    assign empty_o     = ~|valid;

    // Lists never share a line, so only one tail can match
    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(tail_hit))
        else $error("rtab_alloc: several tails hit the checked line");
    assert property (@(posedge clk_i) disable iff (!rst_ni) alloc_link_i |-> check_hit_o)
        else $error("rtab_alloc: link without a check hit");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (alloc_i || alloc_link_i) |-> !full_o)
        else $error("rtab_alloc: allocation while full");
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(alloc_i && alloc_link_i))
        else $error("rtab_alloc: two allocations in one cycle");

endmodule

// ==== logic/rtab_entry.sv ====
/* One slot of the replay table. Holds a waiting request with its list
   links and dependency flags, and reports its status to the allocator
   and to the pop scheduler. IDX is the slot's own index */
module rtab_entry #(
    parameter int unsigned IDX   = 0,
    parameter type         req_t = rtab_pkg::rtab_req_t
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  rtab_pkg::rtab_nline_t  check_nline_i,
    input  logic                   alloc_i,
    input  logic                   alloc_head_i,
    input  req_t                   alloc_req_i,
    input  rtab_pkg::rtab_deps_t   alloc_deps_i,
    input  logic                   link_i,
    input  rtab_pkg::rtab_ptr_t    alloc_ptr_i,
    input  logic                   try_i,
    input  logic                   pop_commit_i,
    input  rtab_pkg::rtab_ptr_t    pop_commit_ptr_i,
    input  logic                   pop_rback_i,
    input  rtab_pkg::rtab_ptr_t    pop_rback_ptr_i,
    input  rtab_pkg::rtab_deps_t   pop_rback_deps_i,
    input  logic                   refill_i,
    input  rtab_pkg::rtab_nline_t  refill_nline_i,
    input  logic                   miss_ready_i,
    output rtab_pkg::rtab_status_t status_o,
    output req_t                   req_o
);
    logic                 valid_q;
    logic                 head_q;
    logic                 tail_q;
    rtab_pkg::rtab_ptr_t  next_q;
    rtab_pkg::rtab_deps_t deps_q;
    rtab_pkg::rtab_deps_t deps_clr;
    rtab_pkg::rtab_deps_t deps_set;
    req_t                 req_q;
    logic                 commit_hit;
    logic                 rback_hit;
    logic                 refill_hit;

    assign commit_hit = pop_commit_i && (pop_commit_ptr_i == rtab_pkg::rtab_ptr_t'(IDX));
    assign rback_hit  = pop_rback_i && (pop_rback_ptr_i == rtab_pkg::rtab_ptr_t'(IDX));

    // A refill of our own line resolves the pending miss
    assign refill_hit              = refill_i && (req_q.nline == refill_nline_i);
    assign deps_clr.mshr_hit       = refill_hit;
    assign deps_clr.mshr_not_ready = miss_ready_i;
    assign deps_set                = rback_hit ? pop_rback_deps_i : '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            head_q  <= 1'b0;
            tail_q  <= 1'b0;
            next_q  <= '0;
            deps_q  <= '0;
        end else begin
            if (alloc_i) begin
                // New entries always go at the end of a list
                valid_q <= 1'b1;
                head_q  <= alloc_head_i;
                tail_q  <= 1'b1;
                deps_q  <= alloc_deps_i;
            end else begin
                if (commit_hit) begin
                    valid_q <= 1'b0;
                end
                // Hidden from the arbiter while the try is in flight
                if (try_i) begin
                    head_q <= 1'b0;
                end else if (rback_hit) begin
                    head_q <= 1'b1;
                end
                if (link_i) begin
                    tail_q <= 1'b0;
                end
                deps_q <= (deps_q & ~deps_clr) | deps_set;
            end
            if (link_i) begin
                next_q <= alloc_ptr_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            req_q <= alloc_req_i;
        end
    end

    assign status_o.valid    = valid_q;
    assign status_o.head     = head_q;
    assign status_o.tail     = tail_q;
    assign status_o.ready    = valid_q & head_q & ~|deps_q;
    assign status_o.line_hit = valid_q & (req_q.nline == check_nline_i);
    assign status_o.next     = next_q;
    assign req_o             = req_q;

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (commit_hit || rback_hit) |-> valid_q)
        else $error("rtab_entry %0d: commit or rollback of an invalid entry", IDX);

endmodule

// ==== logic/rtab_pkg.sv ====
/* Types shared by the replay table modules.
   Refer to them by scoped names from the RTL and the testbench */
`include "rtab_settings.svh"

package rtab_pkg;

    // Index of one table entry
    typedef logic [$clog2(`RTAB_ENTRIES)-1:0] rtab_ptr_t;

    typedef logic [`RTAB_NLINE_WIDTH-1:0] rtab_nline_t;

    // Default payload, any payload with an nline field works
    typedef struct packed {
        rtab_nline_t                   nline;
        logic [`RTAB_OFFSET_WIDTH-1:0] offset;
        logic [`RTAB_ID_WIDTH-1:0]     id;
    } rtab_req_t;

    // Reasons why a request cannot replay yet
    typedef struct packed {
        logic mshr_hit;
        logic mshr_not_ready;
    } rtab_deps_t;

    typedef struct packed {
        logic      valid;
        logic      head;
        logic      tail;
        logic      ready;
        logic      line_hit;
        rtab_ptr_t next;
    } rtab_status_t;

endpackage

// ==== logic/rtab_pop.sv ====
/* Pop scheduler of the replay table. A round-robin arbiter picks a ready
   list head, then the FSM walks the list through its next pointers so
   that requests to one line replay in allocation order */
`include "rtab_settings.svh"

module rtab_pop #(
    parameter type req_t = rtab_pkg::rtab_req_t
) (
    input  logic                                       clk_i,
    input  logic                                       rst_ni,
    input  rtab_pkg::rtab_status_t [`RTAB_ENTRIES-1:0] status_i,
    input  req_t [`RTAB_ENTRIES-1:0]                   reqs_i,
    input  logic                                       pop_try_i,
    input  logic                                       pop_rback_i,
    output logic                                       pop_try_valid_o,
    output req_t                                       pop_try_req_o,
    output rtab_pkg::rtab_ptr_t                        pop_try_ptr_o,
    output logic [`RTAB_ENTRIES-1:0]                   try_bv_o
);
    localparam int N = `RTAB_ENTRIES;

    typedef enum logic [1:0] {
        POP_HEAD,
        POP_NEXT,
        POP_NEXT_WAIT
    } pop_state_e;

    pop_state_e          state_q;
    pop_state_e          state_d;
    rtab_pkg::rtab_ptr_t next_q;
    rtab_pkg::rtab_ptr_t next_d;
    rtab_pkg::rtab_ptr_t rr_q;
    rtab_pkg::rtab_ptr_t gnt_ptr;
    rtab_pkg::rtab_ptr_t sel_ptr;
    logic                gnt_valid;
    logic                head_taken;

    // First ready head at or after the round-robin pointer
    always_comb begin : rr_pick
        int cand;
        gnt_valid = 1'b0;
        gnt_ptr   = '0;
        for (int k = N - 1; k >= 0; k--) begin
            cand = (int'(rr_q) + k) % N;
            if (status_i[cand].ready) begin
                gnt_valid = 1'b1;
                gnt_ptr   = rtab_pkg::rtab_ptr_t'(cand);
            end
        end
    end

    always_comb begin : pop_fsm
        state_d         = state_q;
        next_d          = next_q;
        sel_ptr         = next_q;
        pop_try_valid_o = 1'b1;
        head_taken      = 1'b0;
        case (state_q)
            POP_HEAD: begin
                sel_ptr         = gnt_ptr;
                pop_try_valid_o = gnt_valid;
                if (gnt_valid && pop_try_i && !pop_rback_i) begin
                    head_taken = 1'b1;
                    if (!status_i[gnt_ptr].tail) begin
                        state_d = POP_NEXT;
                        next_d  = status_i[gnt_ptr].next;
                    end
                end
            end
            POP_NEXT, POP_NEXT_WAIT: begin
                // The head just tried may come back, then the rest of the list waits
                if (state_q == POP_NEXT && pop_rback_i) begin
                    state_d = POP_HEAD;
                end else if (pop_try_i) begin
                    if (status_i[next_q].tail) begin
                        state_d = POP_HEAD;
                    end else begin
                        state_d = POP_NEXT;
                        next_d  = status_i[next_q].next;
                    end
                end else begin
                    state_d = POP_NEXT_WAIT;
                end
            end
            default: begin
                state_d = POP_HEAD;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= POP_HEAD;
            next_q  <= '0;
            rr_q    <= '0;
        end else begin
            state_q <= state_d;
            next_q  <= next_d;
            if (head_taken) begin
                rr_q <= rtab_pkg::rtab_ptr_t'((int'(gnt_ptr) + 1) % N);
            end
        end
    end

    always_comb begin : try_decode
        try_bv_o = '0;
        try_bv_o[sel_ptr] = pop_try_i & pop_try_valid_o;
    end

    assign pop_try_ptr_o = sel_ptr;
    assign pop_try_req_o = reqs_i[sel_ptr];

    // Two edges after the try the entry is either gone or a head again
    property p_try_resolved;
        rtab_pkg::rtab_ptr_t p;
        @(posedge clk_i) disable iff (!rst_ni)
        (pop_try_i && pop_try_valid_o, p = pop_try_ptr_o)
            |=> ##1 (!status_i[p].valid || status_i[p].head);
    endproperty

    assert property (p_try_resolved)
        else $error("rtab_pop: accepted try not followed by commit or rollback");
    assert property (@(posedge clk_i) disable iff (!rst_ni) pop_rback_i |-> !pop_try_i)
        else $error("rtab_pop: try accepted during a rollback");

endmodule

// ==== logic/rtab_settings.svh ====
/* Sizes of the replay table and of its default request fields.
   Include it in every file that needs the entry count or a field width */
`ifndef RTAB_SETTINGS_SVH
`define RTAB_SETTINGS_SVH

// Number of table entries
`define RTAB_ENTRIES 4

// Cache-line index width
`define RTAB_NLINE_WIDTH 8

// Word offset inside a line
`define RTAB_OFFSET_WIDTH 4

// Request identifier width
`define RTAB_ID_WIDTH 4

`endif

// ==== logic/rtab_top.sv ====
/* Replay table for a non-blocking cache. Parks requests that cannot be
   served yet and replays them per line, in order, once their dependencies
   clear. Each replay is a try followed by a commit or a rollback */
`include "rtab_settings.svh"

module rtab_top #(
    parameter type req_t = rtab_pkg::rtab_req_t
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  rtab_pkg::rtab_nline_t check_nline_i,
    output logic                  check_hit_o,
    input  logic                  alloc_i,
    input  logic                  alloc_link_i,
    input  req_t                  alloc_req_i,
    input  rtab_pkg::rtab_deps_t  alloc_deps_i,
    output logic                  pop_try_valid_o,
    output req_t                  pop_try_req_o,
    output rtab_pkg::rtab_ptr_t   pop_try_ptr_o,
    input  logic                  pop_try_i,
    input  logic                  pop_commit_i,
    input  rtab_pkg::rtab_ptr_t   pop_commit_ptr_i,
    input  logic                  pop_rback_i,
    input  rtab_pkg::rtab_ptr_t   pop_rback_ptr_i,
    input  rtab_pkg::rtab_deps_t  pop_rback_deps_i,
    input  logic                  refill_i,
    input  rtab_pkg::rtab_nline_t refill_nline_i,
    input  logic                  miss_ready_i,
    output logic                  full_o,
    output logic                  empty_o
);
    localparam int N = `RTAB_ENTRIES;

    rtab_pkg::rtab_status_t [N-1:0] status;
    req_t [N-1:0]                   reqs;
    logic [N-1:0]                   alloc_bv;
    logic [N-1:0]                   link_bv;
    logic [N-1:0]                   try_bv;
    logic                           alloc_head;
    rtab_pkg::rtab_ptr_t            alloc_ptr;

    rtab_alloc i_alloc (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .alloc_i      (alloc_i),
        .alloc_link_i (alloc_link_i),
        .status_i     (status),
        .alloc_bv_o   (alloc_bv),
        .alloc_head_o (alloc_head),
        .link_bv_o    (link_bv),
        .alloc_ptr_o  (alloc_ptr),
        .check_hit_o  (check_hit_o),
        .full_o       (full_o),
        .empty_o      (empty_o)
    );

    for (genvar i = 0; i < N; i++) begin : g_entry
        rtab_entry #(
            .IDX   (i),
            .req_t (req_t)
        ) i_entry (
            .clk_i            (clk_i),
            .rst_ni           (rst_ni),
            .check_nline_i    (check_nline_i),
            .alloc_i          (alloc_bv[i]),
            .alloc_head_i     (alloc_head),
            .alloc_req_i      (alloc_req_i),
            .alloc_deps_i     (alloc_deps_i),
            .link_i           (link_bv[i]),
            .alloc_ptr_i      (alloc_ptr),
            .try_i            (try_bv[i]),
            .pop_commit_i     (pop_commit_i),
            .pop_commit_ptr_i (pop_commit_ptr_i),
            .pop_rback_i      (pop_rback_i),
            .pop_rback_ptr_i  (pop_rback_ptr_i),
            .pop_rback_deps_i (pop_rback_deps_i),
            .refill_i         (refill_i),
            .refill_nline_i   (refill_nline_i),
            .miss_ready_i     (miss_ready_i),
            .status_o         (status[i]),
            .req_o            (reqs[i])
        );
    end

    rtab_pop #(
        .req_t (req_t)
    ) i_pop (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .status_i        (status),
        .reqs_i          (reqs),
        .pop_try_i       (pop_try_i),
        .pop_rback_i     (pop_rback_i),
        .pop_try_valid_o (pop_try_valid_o),
        .pop_try_req_o   (pop_try_req_o),
        .pop_try_ptr_o   (pop_try_ptr_o),
        .try_bv_o        (try_bv)
    );

endmodule

// ==== tb.f ====
+incdir+logic
logic/rtab_pkg.sv
logic/rtab_alloc.sv
logic/rtab_entry.sv
logic/rtab_pop.sv
logic/rtab_top.sv
verification/rtab_tb.sv

// ==== verification/rtab_tb.sv ====
/* Directed testbench for the replay table. Drives rtab_top on the falling
   clock edge and checks allocation, line chaining, dependencies and replay */
`include "rtab_settings.svh"

module rtab_tb;
    localparam int N       = `RTAB_ENTRIES;
    localparam int TIMEOUT = 50;

    logic                  clk_i;
    logic                  rst_ni;
    rtab_pkg::rtab_nline_t check_nline;
    logic                  check_hit;
    logic                  alloc;
    logic                  alloc_link;
    rtab_pkg::rtab_req_t   alloc_req;
    rtab_pkg::rtab_deps_t  alloc_deps;
    logic                  try_valid;
    rtab_pkg::rtab_req_t   try_req;
    rtab_pkg::rtab_ptr_t   try_ptr;
    logic                  pop_try;
    logic                  commit;
    rtab_pkg::rtab_ptr_t   commit_ptr;
    logic                  rback;
    rtab_pkg::rtab_ptr_t   rback_ptr;
    rtab_pkg::rtab_deps_t  rback_deps;
    logic                  refill;
    rtab_pkg::rtab_nline_t refill_nline;
    logic                  miss_ready;
    logic                  full;
    logic                  empty;

    int          value_errors;
    int          other_errors;
    logic [31:0] lcg_state;

    rtab_top i_dut (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .check_nline_i    (check_nline),
        .check_hit_o      (check_hit),
        .alloc_i          (alloc),
        .alloc_link_i     (alloc_link),
        .alloc_req_i      (alloc_req),
        .alloc_deps_i     (alloc_deps),
        .pop_try_valid_o  (try_valid),
        .pop_try_req_o    (try_req),
        .pop_try_ptr_o    (try_ptr),
        .pop_try_i        (pop_try),
        .pop_commit_i     (commit),
        .pop_commit_ptr_i (commit_ptr),
        .pop_rback_i      (rback),
        .pop_rback_ptr_i  (rback_ptr),
        .pop_rback_deps_i (rback_deps),
        .refill_i         (refill),
        .refill_nline_i   (refill_nline),
        .miss_ready_i     (miss_ready),
        .full_o           (full),
        .empty_o          (empty)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Random offset and id for a request on the given line
    function automatic rtab_pkg::rtab_req_t make_req(rtab_pkg::rtab_nline_t nline);
        rtab_pkg::rtab_req_t r;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        r.nline   = nline;
        r.offset  = lcg_state[16 +: `RTAB_OFFSET_WIDTH];
        r.id      = lcg_state[24 +: `RTAB_ID_WIDTH];
        return r;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        value_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("FAILURE: %s", what);
        other_errors++;
    endtask

    task automatic alloc_one(input bit link, input rtab_pkg::rtab_req_t req,
                             input rtab_pkg::rtab_deps_t deps);
        alloc      = !link;
        alloc_link = link;
        alloc_req  = req;
        alloc_deps = deps;
        @(negedge clk_i);
        alloc      = 1'b0;
        alloc_link = 1'b0;
    endtask

    task automatic wait_offer(output bit ok);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!try_valid && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        ok = try_valid;
        if (!ok) begin
            report_failure($sformatf("no replay offer within %0d cycles", TIMEOUT));
        end
    endtask

    // Accept the offered entry and commit it one cycle later
    task automatic pop_entry(output rtab_pkg::rtab_req_t req,
                             output rtab_pkg::rtab_ptr_t ptr, output bit ok);
        wait_offer(ok);
        req = try_req;
        ptr = try_ptr;
        if (ok) begin
            pop_try = 1'b1;
            @(negedge clk_i);
            pop_try    = 1'b0;
            commit     = 1'b1;
            commit_ptr = ptr;
            @(negedge clk_i);
            commit = 1'b0;
        end
    endtask

    task automatic hold_unoffered(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            if (try_valid !== 1'b0) report_value("pop_try_valid_o", try_valid, 0);
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk_i);
        if (empty !== 1'b1) report_value("empty_o", empty, 1);
        if (full !== 1'b0) report_value("full_o", full, 0);
        if (try_valid !== 1'b0) report_value("pop_try_valid_o", try_valid, 0);
    endtask

    task automatic test_single();
        rtab_pkg::rtab_req_t req;
        rtab_pkg::rtab_req_t got;
        rtab_pkg::rtab_ptr_t ptr;
        bit                  ok;
        req = make_req(8'h21);
        alloc_one(1'b0, req, '0);
        if (empty !== 1'b0) report_value("empty_o", empty, 0);
        pop_entry(got, ptr, ok);
        if (ok && got !== req) report_value("pop_try_req_o", got, req);
        if (empty !== 1'b1) report_value("empty_o", empty, 1);
    endtask

    task automatic test_fill_drain();
        rtab_pkg::rtab_req_t exp [N];
        bit                  seen [N];
        rtab_pkg::rtab_req_t got;
        rtab_pkg::rtab_ptr_t ptr;
        bit                  ok;
        bit                  found;
        for (int i = 0; i < N; i++) begin
            exp[i]  = make_req(rtab_pkg::rtab_nline_t'(8'h10 + i));
            seen[i] = 1'b0;
            alloc_one(1'b0, exp[i], '0);
        end
        if (full !== 1'b1) report_value("full_o", full, 1);
        for (int i = 0; i < N; i++) begin
            pop_entry(got, ptr, ok);
            found = 1'b0;
            for (int j = 0; j < N; j++) begin
                if (!found && !seen[j] && got === exp[j]) begin
                    seen[j] = 1'b1;
                    found   = 1'b1;
                end
            end
            if (ok && !found) begin
                report_failure($sformatf("payload 0x%0h replayed twice or never pending", got));
            end
        end
        if (empty !== 1'b1) report_value("empty_o", empty, 1);
    endtask

    // Requests to one line replay in allocation order from the lowest free slots
    task automatic test_same_line();
        rtab_pkg::rtab_req_t exp [3];
        rtab_pkg::rtab_req_t got;
        rtab_pkg::rtab_ptr_t ptr;
        bit                  ok;
        for (int i = 0; i < 3; i++) begin
            exp[i] = make_req(8'h33);
        end
        check_nline = 8'h33;
        alloc_one(1'b0, exp[0], '0);
        for (int i = 1; i < 3; i++) begin
            if (check_hit !== 1'b1) report_value("check_hit_o", check_hit, 1);
            alloc_one(1'b1, exp[i], '0);
        end
        check_nline = 8'h34;
        @(negedge clk_i);
        if (check_hit !== 1'b0) report_value("check_hit_o", check_hit, 0);
        for (int i = 0; i < 3; i++) begin
            pop_entry(got, ptr, ok);
            if (ok && got !== exp[i]) report_value("pop_try_req_o", got, exp[i]);
            if (ok && ptr !== i) report_value("pop_try_ptr_o", ptr, i);
        end
    endtask

    task automatic test_dependencies();
        rtab_pkg::rtab_req_t  req;
        rtab_pkg::rtab_req_t  got;
        rtab_pkg::rtab_ptr_t  ptr;
        rtab_pkg::rtab_deps_t deps;
        bit                   ok;
        req           = make_req(8'h50);
        deps          = '0;
        deps.mshr_hit = 1'b1;
        alloc_one(1'b0, req, deps);
        for (int i = 1; i <= 4; i++) begin
            refill       = 1'b1;
            refill_nline = rtab_pkg::rtab_nline_t'(8'h50 + i);
            @(negedge clk_i);
            if (try_valid !== 1'b0) report_value("pop_try_valid_o", try_valid, 0);
        end
        refill_nline = 8'h50;
        @(negedge clk_i);
        refill = 1'b0;
        pop_entry(got, ptr, ok);
        if (ok && got !== req) report_value("pop_try_req_o", got, req);

        req                 = make_req(8'h60);
        deps                = '0;
        deps.mshr_not_ready = 1'b1;
        alloc_one(1'b0, req, deps);
        hold_unoffered(4);
        miss_ready = 1'b1;
        @(negedge clk_i);
        miss_ready = 1'b0;
        pop_entry(got, ptr, ok);
        if (ok && got !== req) report_value("pop_try_req_o", got, req);
    endtask

    task automatic test_rollback();
        rtab_pkg::rtab_req_t req;
        rtab_pkg::rtab_req_t got;
        rtab_pkg::rtab_ptr_t ptr;
        rtab_pkg::rtab_ptr_t first_ptr;
        bit                  ok;
        req = make_req(8'h70);
        alloc_one(1'b0, req, '0);
        wait_offer(ok);
        if (ok) begin
            first_ptr = try_ptr;
            if (try_req !== req) report_value("pop_try_req_o", try_req, req);
            pop_try = 1'b1;
            @(negedge clk_i);
            pop_try                   = 1'b0;
            rback                     = 1'b1;
            rback_ptr                 = first_ptr;
            rback_deps                = '0;
            rback_deps.mshr_not_ready = 1'b1;
            @(negedge clk_i);
            rback = 1'b0;
            hold_unoffered(4);
            miss_ready = 1'b1;
            @(negedge clk_i);
            miss_ready = 1'b0;
            pop_entry(got, ptr, ok);
            if (ok && ptr !== first_ptr) report_value("pop_try_ptr_o", ptr, first_ptr);
            if (ok && got !== req) report_value("pop_try_req_o", got, req);
        end
        if (empty !== 1'b1) report_value("empty_o", empty, 1);
    endtask

    initial begin
        value_errors = 0;
        other_errors = 0;
        lcg_state    = 32'hc372_6989;
        rst_ni       = 1'b0;
        check_nline  = '0;
        alloc        = 1'b0;
        alloc_link   = 1'b0;
        alloc_req    = '0;
        alloc_deps   = '0;
        pop_try      = 1'b0;
        commit       = 1'b0;
        commit_ptr   = '0;
        rback        = 1'b0;
        rback_ptr    = '0;
        rback_deps   = '0;
        refill       = 1'b0;
        refill_nline = '0;
        miss_ready   = 1'b0;
        repeat (5) @(negedge clk_i);
        rst_ni = 1'b1;

        test_reset_state();
        test_single();
        test_fill_drain();
        test_same_line();
        test_dependencies();
        test_rollback();

        $display("Summary: %0d value errors, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
